//--- list.f
rtl/video_pkg.sv
rtl/frame_source.sv
rtl/pixel_op.sv
rtl/stream_reg_slice.sv
rtl/video_pattern_top.sv
testbench/video_pattern_assert.sv
testbench/tb_video_pattern.sv

//--- rtl/frame_source.sv
`timescale 1ns/1ps

module frame_source (
    input  logic                            aclk,
    input  logic                            aresetn,

    input  logic                            enable,
    output logic                            busy,

    output logic                            src_tuser,
    output logic                            src_tlast,
    output logic [video_pkg::TDATA_WIDTH-1:0] src_tdata,
    output logic [video_pkg::X_WIDTH-1:0]   src_tx,
    output logic [video_pkg::Y_WIDTH-1:0]   src_ty,
    output logic [video_pkg::F_WIDTH-1:0]   src_tf,
    output logic                            src_tvalid,
    input  logic                            src_tready
);
    import video_pkg::*;

    src_state_e         state;
    logic [X_WIDTH-1:0] x_cnt;
    logic [Y_WIDTH-1:0] y_cnt;
    logic [F_WIDTH-1:0] f_cnt;
    // Shared by horizontal and vertical blanking
    logic [15:0]        blank_cnt;
    logic               beat;

    assign beat = src_tvalid && src_tready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state     <= SRC_IDLE;
            busy      <= 1'b0;
            x_cnt     <= '0;
            y_cnt     <= '0;
            f_cnt     <= '0;
            blank_cnt <= '0;
        end else begin
            case (state)
                SRC_IDLE: begin
                    if (enable) begin
                        state <= SRC_ACTIVE;
                        busy  <= 1'b1;
                        x_cnt <= '0;
                        y_cnt <= '0;
                    end
                end

                // Pixel counter moves only on accepted beats
                SRC_ACTIVE: begin
                    if (beat) begin
                        if (x_cnt == X_WIDTH'(X_NUM - 1)) begin
                            x_cnt     <= '0;
                            blank_cnt <= '0;
                            state     <= SRC_HBLANK;
                        end else begin
                            x_cnt <= x_cnt + 1'b1;
                        end
                    end
                end

                // Blanking runs on every clock, no stall
                SRC_HBLANK: begin
                    blank_cnt <= blank_cnt + 1'b1;
                    if (blank_cnt == 16'(X_BLANK - 1)) begin
                        blank_cnt <= '0;
                        if (y_cnt == Y_WIDTH'(Y_NUM - 1)) begin
                            y_cnt <= '0;
                            state <= SRC_VBLANK;
                        end else begin
                            y_cnt <= y_cnt + 1'b1;
                            state <= SRC_ACTIVE;
                        end
                    end
                end

                // Y_BLANK full lines of idle time
                SRC_VBLANK: begin
                    blank_cnt <= blank_cnt + 1'b1;
                    if (blank_cnt == 16'(Y_BLANK * (X_NUM + X_BLANK) - 1)) begin
                        blank_cnt <= '0;
                        state     <= SRC_IDLE;
                        busy      <= 1'b0;
                        f_cnt     <= f_cnt + 1'b1;
                    end
                end

                default: begin
                    state <= SRC_IDLE;
                end
            endcase
        end
    end

    // Coordinate pattern straight from the counters
    assign src_tvalid = (state == SRC_ACTIVE);
    assign src_tuser  = (x_cnt == '0) && (y_cnt == '0);
    assign src_tlast  = (x_cnt == X_WIDTH'(X_NUM - 1));
    assign src_tdata  = {f_cnt[DATA_WIDTH-1:0], y_cnt[DATA_WIDTH-1:0], x_cnt[DATA_WIDTH-1:0]};
    assign src_tx     = x_cnt;
    assign src_ty     = y_cnt;
    assign src_tf     = f_cnt;

endmodule

//--- rtl/pixel_op.sv
`timescale 1ns/1ps

module pixel_op (
    input  logic                              aclk,
    input  logic                              aresetn,

    input  video_pkg::pixel_op_e              op,

    input  logic                              src_tuser,
    input  logic                              src_tlast,
    input  logic [video_pkg::TDATA_WIDTH-1:0] src_tdata,
    input  logic [video_pkg::X_WIDTH-1:0]     src_tx,
    input  logic [video_pkg::Y_WIDTH-1:0]     src_ty,
    input  logic [video_pkg::F_WIDTH-1:0]     src_tf,
    input  logic                              src_tvalid,
    output logic                              src_tready,

    output logic                              op_tuser,
    output logic                              op_tlast,
    output logic [video_pkg::TDATA_WIDTH-1:0] op_tdata,
    output logic [video_pkg::X_WIDTH-1:0]     op_tx,
    output logic [video_pkg::Y_WIDTH-1:0]     op_ty,
    output logic [video_pkg::F_WIDTH-1:0]     op_tf,
    output logic                              op_tvalid,
    input  logic                              op_tready
);
    import video_pkg::*;

    // Component times weight, full product width
    function automatic logic [2*DATA_WIDTH-1:0] weigh(
        input logic [DATA_WIDTH-1:0] comp,
        input int                    weight
    );
        return (2*DATA_WIDTH)'(comp) * (2*DATA_WIDTH)'(weight);
    endfunction

    pixel_op_e              cur_op;
    pixel_op_e              beat_op;
    logic                   advance;
    logic [TDATA_WIDTH-1:0] mod_data;

    logic                   s1_valid;
    logic                   s1_user;
    logic                   s1_last;
    logic [TDATA_WIDTH-1:0] s1_data;
    logic [X_WIDTH-1:0]     s1_x;
    logic [Y_WIDTH-1:0]     s1_y;
    logic [F_WIDTH-1:0]     s1_f;
    logic                   s1_luma;
    logic [2*DATA_WIDTH-1:0] s1_p0;
    logic [2*DATA_WIDTH-1:0] s1_p1;
    logic [2*DATA_WIDTH-1:0] s1_p2;

    logic [2*DATA_WIDTH+1:0] luma_sum;
    logic [DATA_WIDTH-1:0]   luma_y;

    // Whole pipe moves when the last stage is free or drained
    assign advance    = !op_tvalid || op_tready;
    assign src_tready = advance;

    // Start of frame picks up the new operation immediately
    assign beat_op = src_tuser ? op : cur_op;

    always_comb begin
        mod_data = src_tdata;
        case (beat_op)
            OP_INVERT: begin
                for (int i = 0; i < COMPONENTS; i++) begin
                    mod_data[i*DATA_WIDTH +: DATA_WIDTH] =
                        {DATA_WIDTH{1'b1}} - src_tdata[i*DATA_WIDTH +: DATA_WIDTH];
                end
            end
            OP_SWAP: begin
                for (int i = 0; i < COMPONENTS; i++) begin
                    mod_data[i*DATA_WIDTH +: DATA_WIDTH] =
                        src_tdata[(COMPONENTS-1-i)*DATA_WIDTH +: DATA_WIDTH];
                end
            end
            default: begin
                mod_data = src_tdata;
            end
        endcase
    end

    // Weights sum to 256, so bits above 15 stay zero
    assign luma_sum = {2'b00, s1_p0} + {2'b00, s1_p1} + {2'b00, s1_p2};
    assign luma_y   = luma_sum[2*DATA_WIDTH-1:DATA_WIDTH];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            s1_valid  <= 1'b0;
            op_tvalid <= 1'b0;
            cur_op    <= OP_PASS;
        end else if (advance) begin
            s1_valid  <= src_tvalid;
            op_tvalid <= s1_valid;
            if (src_tvalid && src_tuser) begin
                cur_op <= op;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (advance) begin
            // Stage 1
            s1_user <= src_tuser;
            s1_last <= src_tlast;
            s1_data <= mod_data;
            s1_x    <= src_tx;
            s1_y    <= src_ty;
            s1_f    <= src_tf;
            s1_luma <= (beat_op == OP_LUMA);
            s1_p0   <= weigh(src_tdata[0*DATA_WIDTH +: DATA_WIDTH], LUMA_R);
            s1_p1   <= weigh(src_tdata[1*DATA_WIDTH +: DATA_WIDTH], LUMA_G);
            s1_p2   <= weigh(src_tdata[2*DATA_WIDTH +: DATA_WIDTH], LUMA_B);

            // Stage 2
            op_tuser <= s1_user;
            op_tlast <= s1_last;
            op_tdata <= s1_luma ? {COMPONENTS{luma_y}} : s1_data;
            op_tx    <= s1_x;
            op_ty    <= s1_y;
            op_tf    <= s1_f;
        end
    end

endmodule

//--- rtl/stream_reg_slice.sv
`timescale 1ns/1ps

module stream_reg_slice (
    input  logic                              aclk,
    input  logic                              aresetn,

    input  logic                              op_tuser,
    input  logic                              op_tlast,
    input  logic [video_pkg::TDATA_WIDTH-1:0] op_tdata,
    input  logic [video_pkg::X_WIDTH-1:0]     op_tx,
    input  logic [video_pkg::Y_WIDTH-1:0]     op_ty,
    input  logic [video_pkg::F_WIDTH-1:0]     op_tf,
    input  logic                              op_tvalid,
    output logic                              op_tready,

    output logic                              m_tuser,
    output logic                              m_tlast,
    output logic [video_pkg::TDATA_WIDTH-1:0] m_tdata,
    output logic [video_pkg::X_WIDTH-1:0]     m_tx,
    output logic [video_pkg::Y_WIDTH-1:0]     m_ty,
    output logic [video_pkg::F_WIDTH-1:0]     m_tf,
    output logic                              m_tvalid,
    input  logic                              m_tready
);
    import video_pkg::*;

    // Whole beat packed as one word: user, last, data, x, y, f
    logic [2+TDATA_WIDTH+X_WIDTH+Y_WIDTH+F_WIDTH-1:0] in_pay, skid_pay;

    logic in_fire;
    logic out_free;
    logic skid_valid;
    logic skid_valid_next;

    assign in_pay   = {op_tuser, op_tlast, op_tdata, op_tx, op_ty, op_tf};
    assign in_fire  = op_tvalid && op_tready;
    assign out_free = !m_tvalid || m_tready;

    // Ready only goes low when the skid register is occupied
    assign skid_valid_next = out_free ? 1'b0 : (skid_valid || in_fire);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            m_tvalid   <= 1'b0;
            skid_valid <= 1'b0;
            op_tready  <= 1'b0;
        end else begin
            skid_valid <= skid_valid_next;
            op_tready  <= !skid_valid_next;
            if (out_free) begin
                m_tvalid <= skid_valid || in_fire;
            end
        end
    end

    always_ff @(posedge aclk) begin
        // Drain the parked beat before a new one
        if (out_free) begin
            {m_tuser, m_tlast, m_tdata, m_tx, m_ty, m_tf} <= skid_valid ? skid_pay : in_pay;
        end
        if (!out_free && in_fire) begin
            skid_pay <= in_pay;
        end
    end

endmodule

//--- rtl/video_pattern_top.sv
`timescale 1ns/1ps

module video_pattern_top (
    input  logic                              aclk,
    input  logic                              aresetn,

    input  logic                              enable,
    input  video_pkg::pixel_op_e              op,
    output logic                              busy,

    output logic                              m_tuser,
    output logic                              m_tlast,
    output logic [video_pkg::TDATA_WIDTH-1:0] m_tdata,
    output logic [video_pkg::X_WIDTH-1:0]     m_tx,
    output logic [video_pkg::Y_WIDTH-1:0]     m_ty,
    output logic [video_pkg::F_WIDTH-1:0]     m_tf,
    output logic                              m_tvalid,
    input  logic                              m_tready
);
    import video_pkg::*;

    // Source to pixel operation
    logic                   src_tuser;
    logic                   src_tlast;
    logic [TDATA_WIDTH-1:0] src_tdata;
    logic [X_WIDTH-1:0]     src_tx;
    logic [Y_WIDTH-1:0]     src_ty;
    logic [F_WIDTH-1:0]     src_tf;
    logic                   src_tvalid;
    logic                   src_tready;

    // Pixel operation to output slice
    logic                   op_tuser;
    logic                   op_tlast;
    logic [TDATA_WIDTH-1:0] op_tdata;
    logic [X_WIDTH-1:0]     op_tx;
    logic [Y_WIDTH-1:0]     op_ty;
    logic [F_WIDTH-1:0]     op_tf;
    logic                   op_tvalid;
    logic                   op_tready;

    frame_source source_i (
        .aclk, .aresetn, .enable, .busy,
        .src_tuser, .src_tlast, .src_tdata, .src_tx, .src_ty, .src_tf,
        .src_tvalid, .src_tready
    );

    pixel_op pixel_op_i (
        .aclk, .aresetn, .op,
        .src_tuser, .src_tlast, .src_tdata, .src_tx, .src_ty, .src_tf,
        .src_tvalid, .src_tready,
        .op_tuser, .op_tlast, .op_tdata, .op_tx, .op_ty, .op_tf,
        .op_tvalid, .op_tready
    );

    stream_reg_slice slice_i (
        .aclk, .aresetn,
        .op_tuser, .op_tlast, .op_tdata, .op_tx, .op_ty, .op_tf,
        .op_tvalid, .op_tready,
        .m_tuser, .m_tlast, .m_tdata, .m_tx, .m_ty, .m_tf,
        .m_tvalid, .m_tready
    );

endmodule

//--- rtl/video_pkg.sv
package video_pkg;

    // Pixel format
    localparam int COMPONENTS  = 3;
    localparam int DATA_WIDTH  = 8;
    // Component 0 sits in the lowest byte
    localparam int TDATA_WIDTH = COMPONENTS * DATA_WIDTH;

    // Raster geometry
    localparam int X_NUM   = 16;
    localparam int Y_NUM   = 4;
    localparam int X_BLANK = 2;
    localparam int Y_BLANK = 1;

    // Sideband widths
    localparam int X_WIDTH = 8;
    localparam int Y_WIDTH = 8;
    // Frame count wraps at this width
    localparam int F_WIDTH = 8;

    // Luma weights, sum is 256 so the result is a right shift by 8
    localparam int LUMA_R = 77;
    localparam int LUMA_G = 150;
    localparam int LUMA_B = 29;

    // Operation applied by the pixel pipeline
    typedef enum logic [1:0] {
        OP_PASS   = 2'd0,
        OP_INVERT = 2'd1,
        OP_SWAP   = 2'd2,
        OP_LUMA   = 2'd3
    } pixel_op_e;

    // Frame source FSM
    typedef enum logic [1:0] {
        SRC_IDLE   = 2'd0,
        SRC_ACTIVE = 2'd1,
        SRC_HBLANK = 2'd2,
        SRC_VBLANK = 2'd3
    } src_state_e;

endpackage

//--- testbench/tb_video_pattern.sv
`timescale 1ns/1ps

module tb_video_pattern;
    import video_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;
    localparam int FRAME_BEATS    = X_NUM * Y_NUM;

    logic                   aclk;
    logic                   aresetn;
    logic                   enable;
    pixel_op_e              op;
    logic                   busy;
    logic                   m_tuser;
    logic                   m_tlast;
    logic [TDATA_WIDTH-1:0] m_tdata;
    logic [X_WIDTH-1:0]     m_tx;
    logic [Y_WIDTH-1:0]     m_ty;
    logic [F_WIDTH-1:0]     m_tf;
    logic                   m_tvalid;
    logic                   m_tready;

    integer    seed = 32'hff46_56dc;
    bit        random_ready;
    bit        aborted;
    int        errors;
    int        checks;
    int        tests;
    int        beat_count;
    int        beats_expected;
    int        exp_x;
    int        exp_y;
    int        exp_f;
    pixel_op_e frame_op;
    // Operation of each started frame in start order
    pixel_op_e op_queue[$];

    video_pattern_top dut_i (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    // Sink ready held high or random
    initial begin
        m_tready <= 1'b1;
        forever begin
            @(posedge aclk);
            m_tready <= random_ready ? 1'($random(seed)) : 1'b1;
        end
    end

    function automatic logic [TDATA_WIDTH-1:0] expected_pixel(
        input int        x,
        input int        y,
        input int        f,
        input pixel_op_e sel
    );
        int c0;
        int c1;
        int c2;
        int l;
        c0 = x % 256;
        c1 = y % 256;
        c2 = f % 256;
        case (sel)
            OP_INVERT: return {8'(255 - c2), 8'(255 - c1), 8'(255 - c0)};
            OP_SWAP:   return {8'(c0), 8'(c1), 8'(c2)};
            OP_LUMA: begin
                l = (LUMA_R * c0 + LUMA_G * c1 + LUMA_B * c2) / 256;
                return {8'(l), 8'(l), 8'(l)};
            end
            default:   return {8'(c2), 8'(c1), 8'(c0)};
        endcase
    endfunction

    task automatic fail_value(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
        errors++;
        aborted = 1'b1;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("[DONE] %s: ok", name);
        end else begin
            $display("[DONE] %s: %0d error(s)", name, errors - errors_before);
        end
    endtask

    // Compare each accepted beat with the reference and the raster order
    initial begin
        forever begin
            @(negedge aclk);
            if (aresetn && m_tvalid && m_tready) begin
                if (exp_x == 0 && exp_y == 0) begin
                    if (op_queue.size() == 0) begin
                        $display("Output beat arrived with no frame started at %0t ns", $time);
                        errors++;
                    end else begin
                        frame_op = op_queue.pop_front();
                    end
                end
                checks++;
                if (m_tx != X_WIDTH'(exp_x) || m_ty != Y_WIDTH'(exp_y) ||
                    m_tf != F_WIDTH'(exp_f)) begin
                    fail_value($sformatf("position %0d,%0d,%0d expected %0d,%0d,%0d",
                        m_tx, m_ty, m_tf, exp_x, exp_y, exp_f));
                end
                if (m_tuser != (exp_x == 0 && exp_y == 0) || m_tlast != (exp_x == X_NUM - 1)) begin
                    fail_value($sformatf("tuser %0b tlast %0b at x %0d y %0d",
                        m_tuser, m_tlast, exp_x, exp_y));
                end
                if (m_tdata != expected_pixel(exp_x, exp_y, exp_f, frame_op)) begin
                    fail_value($sformatf("tdata %h expected %h, op %s", m_tdata,
                        expected_pixel(exp_x, exp_y, exp_f, frame_op), frame_op.name()));
                end
                if (frame_op == OP_LUMA &&
                    (m_tdata[7:0] != m_tdata[15:8] || m_tdata[15:8] != m_tdata[23:16])) begin
                    fail_value($sformatf("luma components differ in %h", m_tdata));
                end
                beat_count++;
                exp_x++;
                if (exp_x == X_NUM) begin
                    exp_x = 0;
                    exp_y++;
                    if (exp_y == Y_NUM) begin
                        exp_y = 0;
                        exp_f = (exp_f + 1) % 256;
                    end
                end
            end
        end
    end

    // Wait for an idle source, then pulse enable for one cycle
    task automatic start_frame(input pixel_op_e sel);
        int cycles;
        if (aborted) return;
        cycles = 0;
        do begin
            @(negedge aclk);
            cycles++;
        end while (busy && cycles < TIMEOUT_CYCLES);
        if (busy) begin
            report_timeout("the source to go idle");
        end else begin
            op_queue.push_back(sel);
            beats_expected += FRAME_BEATS;
            @(posedge aclk);
            op     <= sel;
            enable <= 1'b1;
            @(posedge aclk);
            enable <= 1'b0;
        end
    endtask

    task automatic wait_frame_done();
        int cycles;
        bit busy_seen;
        if (aborted) return;
        cycles    = 0;
        busy_seen = 1'b0;
        do begin
            @(negedge aclk);
            cycles++;
            if (busy) begin
                busy_seen = 1'b1;
            end
        end while ((busy || beat_count < beats_expected) && cycles < TIMEOUT_CYCLES);
        if (busy || beat_count < beats_expected) begin
            report_timeout("the frame to finish and drain");
        end else begin
            checks++;
            if (!busy_seen) begin
                fail_value("busy never went high during the frame");
            end
            // Idle window catches extra beats
            repeat (6) @(negedge aclk);
            checks++;
            if (beat_count != beats_expected) begin
                fail_value($sformatf("%0d beats, expected %0d", beat_count, beats_expected));
            end
        end
    endtask

    initial begin
        int base;
        int edges;
        int cycles;
        int total;
        aresetn <= 1'b0;
        enable  <= 1'b0;
        op      <= OP_PASS;
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;

        base = errors;
        repeat (20) begin
            @(negedge aclk);
            checks++;
            if (busy || m_tvalid) begin
                fail_value("busy or m_tvalid high with enable low");
            end
        end
        finish_test("reset", base);

        if (!aborted) begin
            base = errors;
            start_frame(OP_PASS);
            // Edge 1 samples enable and the first output follows edge 4
            edges = 0;
            do begin
                @(negedge aclk);
                edges++;
            end while (!m_tvalid && edges < TIMEOUT_CYCLES);
            if (!m_tvalid) begin
                report_timeout("the first m_tvalid");
            end else if (edges != 4) begin
                fail_value($sformatf("first m_tvalid after %0d edges, expected 4", edges));
            end
            wait_frame_done();
            finish_test("pass frame", base);
        end

        if (!aborted) begin
            base = errors;
            start_frame(OP_INVERT);
            wait_frame_done();
            start_frame(OP_SWAP);
            wait_frame_done();
            finish_test("invert and swap", base);
        end

        if (!aborted) begin
            base = errors;
            start_frame(OP_LUMA);
            wait_frame_done();
            finish_test("luma", base);
        end

        if (!aborted) begin
            base = errors;
            random_ready = 1'b1;
            start_frame(OP_INVERT);
            cycles = 0;
            while (beat_count < beats_expected - FRAME_BEATS + 20 && cycles < TIMEOUT_CYCLES) begin
                @(negedge aclk);
                cycles++;
            end
            if (beat_count < beats_expected - FRAME_BEATS + 20) begin
                report_timeout("the middle of the frame");
            end
            // New operation must wait for the next start of frame
            @(posedge aclk);
            op <= OP_SWAP;
            wait_frame_done();
            start_frame(OP_SWAP);
            wait_frame_done();
            random_ready = 1'b0;
            finish_test("back-pressure", base);
        end

        total = errors + dut_i.assert_i.assert_errors;
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- testbench/video_pattern_assert.sv
`timescale 1ns/1ps

module video_pattern_assert (
    input logic                              aclk,
    input logic                              aresetn,
    input logic                              m_tuser,
    input logic                              m_tlast,
    input logic [video_pkg::TDATA_WIDTH-1:0] m_tdata,
    input logic [video_pkg::X_WIDTH-1:0]     m_tx,
    input logic [video_pkg::Y_WIDTH-1:0]     m_ty,
    input logic [video_pkg::F_WIDTH-1:0]     m_tf,
    input logic                              m_tvalid,
    input logic                              m_tready
);
    import video_pkg::*;

    int assert_errors = 0;

    logic [1+TDATA_WIDTH+X_WIDTH+Y_WIDTH+F_WIDTH:0] payload;

    assign payload = {m_tuser, m_tlast, m_tdata, m_tx, m_ty, m_tf};

    // Stalled beat keeps valid and payload
    hold_a: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable(payload))
    else begin
        $error("m_tvalid or payload changed while stalled");
        assert_errors++;
    end

    user_a: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && m_tuser |-> m_tx == '0 && m_ty == '0)
    else begin
        $error("tuser away from the frame origin");
        assert_errors++;
    end

    last_a: assert property (@(posedge aclk) disable iff (!aresetn)
        m_tvalid && m_tlast |-> m_tx == X_WIDTH'(X_NUM - 1))
    else begin
        $error("tlast away from the line end");
        assert_errors++;
    end

    reset_a: assert property (@(posedge aclk) !aresetn |=> !m_tvalid)
    else begin
        $error("m_tvalid high during reset");
        assert_errors++;
    end

endmodule

bind video_pattern_top video_pattern_assert assert_i (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .m_tuser  (m_tuser),
    .m_tlast  (m_tlast),
    .m_tdata  (m_tdata),
    .m_tx     (m_tx),
    .m_ty     (m_ty),
    .m_tf     (m_tf),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready)
);
